// ==== src/dc_tag_pkg.sv ====
package dc_tag_pkg;

  // physical address geometry
  localparam int PADDR_W = 44;
  localparam int OFFSET_W = 6;

  // bit 6 picks the bank and bits 12..7 the row inside it
  localparam int BANK_IDX_W = 6;
  localparam int BANK_ROWS = 1 << BANK_IDX_W;

  // line address is the address without its offset
  localparam int LINE_W = PADDR_W - OFFSET_W;

  // tag is address bits 43..13
  localparam int TAG_W = 31;

  localparam int N_WAYS = 4;
  localparam int WAY_W = 2;

  // access size in bytes, 1 to 8
  localparam int SIZE_W = 4;

  // payload of one tag bank row
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             excl;
  } dc_tag_entry_t;

endpackage

// ==== src/dc_tag_ram.sv ====
`timescale 1ns/1ps

// one read port, one write port
// read goes through a registered address, so a write to the same row is seen at once
module dc_tag_ram #(
  parameter type payload_t = logic,
  parameter int DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_clk_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output payload_t                 rd_data,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  payload_t                 wr_data,
  input  logic                     wr_en
);

  payload_t mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] rd_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_clk_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // write first
  assign rd_data = mem[rd_addr_q];

  a_rd_addr_known: assert property (
    @(posedge clk) disable iff (rst)
    rd_clk_en |-> !$isunknown(rd_addr)
  );

endmodule

// ==== src/dc_tag_req_stage.sv ====
`timescale 1ns/1ps

module dc_tag_req_stage (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              req_valid,
  input  logic [dc_tag_pkg::PADDR_W-1:0]    req_addr,
  input  logic [dc_tag_pkg::SIZE_W-1:0]     req_size,
  input  logic                              fill_en,
  input  logic [dc_tag_pkg::PADDR_W-1:0]    fill_addr,
  input  logic [dc_tag_pkg::WAY_W-1:0]      fill_way,
  input  logic                              fill_excl,
  input  logic                              inv_en,
  input  logic [dc_tag_pkg::PADDR_W-1:0]    inv_addr,
  output logic                              init_busy,
  output logic                              rd_en,
  output logic [dc_tag_pkg::BANK_IDX_W-1:0] rd_even_idx,
  output logic [dc_tag_pkg::BANK_IDX_W-1:0] rd_odd_idx,
  output logic [dc_tag_pkg::TAG_W-1:0]      rd_even_tag,
  output logic [dc_tag_pkg::TAG_W-1:0]      rd_odd_tag,
  output logic                              rd_lo_odd,
  output logic                              rd_split,
  output logic [dc_tag_pkg::N_WAYS-1:0]     wr_way_en,
  output logic                              wr_odd,
  output logic                              wr_both,
  output logic [dc_tag_pkg::BANK_IDX_W-1:0] wr_idx,
  output dc_tag_pkg::dc_tag_entry_t         wr_entry,
  output logic                              wr_valid
);
  import dc_tag_pkg::*;

  logic [LINE_W-1:0] line_lo;
  logic [LINE_W-1:0] line_hi;
  logic [LINE_W-1:0] line_even;
  logic [LINE_W-1:0] line_odd;
  logic [OFFSET_W:0] span;
  logic split;
  logic [BANK_IDX_W-1:0] sweep_cnt;

  assign line_lo = req_addr[PADDR_W-1:OFFSET_W];
  assign line_hi = line_lo + LINE_W'(1);
  assign span = {1'b0, req_addr[OFFSET_W-1:0]} + (OFFSET_W+1)'(req_size);
  assign split = span > (OFFSET_W+1)'(1 << OFFSET_W);

  // low line goes to the bank its bit 0 picks and the other bank always gets the high line
  assign line_even = line_lo[0] ? line_hi : line_lo;
  assign line_odd = line_lo[0] ? line_lo : line_hi;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en <= 1'b0;
    end else begin
      rd_en <= req_valid && !init_busy;
    end
    if (req_valid) begin
      rd_even_idx <= line_even[BANK_IDX_W:1];
      rd_odd_idx <= line_odd[BANK_IDX_W:1];
      rd_even_tag <= line_even[LINE_W-1:BANK_IDX_W+1];
      rd_odd_tag <= line_odd[LINE_W-1:BANK_IDX_W+1];
      rd_lo_odd <= line_lo[0];
      rd_split <= split;
    end
  end

  // valid sweep clears one row of both banks per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      sweep_cnt <= '0;
    end else if (init_busy) begin
      sweep_cnt <= sweep_cnt + BANK_IDX_W'(1);
      if (sweep_cnt == '1) begin
        init_busy <= 1'b0;
      end
    end
  end

  // the sweep wins over an invalidate and an invalidate over a fill
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_way_en <= '0;
    end else if (init_busy || inv_en) begin
      wr_way_en <= '1;
    end else if (fill_en) begin
      wr_way_en <= N_WAYS'(1) << fill_way;
    end else begin
      wr_way_en <= '0;
    end
    if (init_busy) begin
      wr_both <= 1'b1;
      wr_odd <= 1'b0;
      wr_idx <= sweep_cnt;
      wr_valid <= 1'b0;
    end else if (inv_en) begin
      wr_both <= 1'b0;
      wr_odd <= inv_addr[OFFSET_W];
      wr_idx <= inv_addr[OFFSET_W+BANK_IDX_W:OFFSET_W+1];
      wr_valid <= 1'b0;
    end else begin
      wr_both <= 1'b0;
      wr_odd <= fill_addr[OFFSET_W];
      wr_idx <= fill_addr[OFFSET_W+BANK_IDX_W:OFFSET_W+1];
      wr_valid <= 1'b1;
    end
    wr_entry.tag <= fill_addr[PADDR_W-1:PADDR_W-TAG_W];
    wr_entry.excl <= fill_excl;
  end

  a_no_fill_and_inv: assert property (
    @(posedge clk) disable iff (rst)
    !(fill_en && inv_en)
  );

  a_no_write_during_init: assert property (
    @(posedge clk) disable iff (rst)
    init_busy |-> !(fill_en || inv_en)
  );

endmodule

// ==== src/dc_tag_way.sv ====
`timescale 1ns/1ps

module dc_tag_way (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              rd_en,
  input  logic [dc_tag_pkg::BANK_IDX_W-1:0] rd_even_idx,
  input  logic [dc_tag_pkg::BANK_IDX_W-1:0] rd_odd_idx,
  input  logic [dc_tag_pkg::TAG_W-1:0]      rd_even_tag,
  input  logic [dc_tag_pkg::TAG_W-1:0]      rd_odd_tag,
  input  logic                              wr_en,
  input  logic                              wr_odd,
  input  logic                              wr_both,
  input  logic [dc_tag_pkg::BANK_IDX_W-1:0] wr_idx,
  input  dc_tag_pkg::dc_tag_entry_t         wr_entry,
  input  logic                              wr_valid,
  output logic                              hit_even,
  output logic                              hit_odd,
  output logic                              excl_even,
  output logic                              excl_odd
);
  import dc_tag_pkg::*;

  dc_tag_entry_t even_entry;
  dc_tag_entry_t odd_entry;
  logic even_vld;
  logic odd_vld;
  logic [TAG_W-1:0] even_tag_q;
  logic [TAG_W-1:0] odd_tag_q;
  logic rd_en_q;
  logic tag_even_we;
  logic tag_odd_we;
  logic vld_even_we;
  logic vld_odd_we;

  // tags only change on a fill, valid bits on every write
  assign tag_even_we = wr_en && wr_valid && !wr_odd;
  assign tag_odd_we = wr_en && wr_valid && wr_odd;
  assign vld_even_we = wr_en && (wr_both || !wr_odd);
  assign vld_odd_we = wr_en && (wr_both || wr_odd);

  dc_tag_ram #(
    .payload_t(dc_tag_entry_t),
    .DEPTH(BANK_ROWS)
  ) even_tag_i (
    .clk(clk),
    .rst(rst),
    .rd_clk_en(rd_en),
    .rd_addr(rd_even_idx),
    .rd_data(even_entry),
    .wr_addr(wr_idx),
    .wr_data(wr_entry),
    .wr_en(tag_even_we)
  );

  dc_tag_ram #(
    .payload_t(dc_tag_entry_t),
    .DEPTH(BANK_ROWS)
  ) odd_tag_i (
    .clk(clk),
    .rst(rst),
    .rd_clk_en(rd_en),
    .rd_addr(rd_odd_idx),
    .rd_data(odd_entry),
    .wr_addr(wr_idx),
    .wr_data(wr_entry),
    .wr_en(tag_odd_we)
  );

  dc_tag_ram #(
    .payload_t(logic),
    .DEPTH(BANK_ROWS)
  ) even_vld_i (
    .clk(clk),
    .rst(rst),
    .rd_clk_en(rd_en),
    .rd_addr(rd_even_idx),
    .rd_data(even_vld),
    .wr_addr(wr_idx),
    .wr_data(wr_valid),
    .wr_en(vld_even_we)
  );

  dc_tag_ram #(
    .payload_t(logic),
    .DEPTH(BANK_ROWS)
  ) odd_vld_i (
    .clk(clk),
    .rst(rst),
    .rd_clk_en(rd_en),
    .rd_addr(rd_odd_idx),
    .rd_data(odd_vld),
    .wr_addr(wr_idx),
    .wr_data(wr_valid),
    .wr_en(vld_odd_we)
  );

  // compare tags follow the bank read address by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
    if (rd_en) begin
      even_tag_q <= rd_even_tag;
      odd_tag_q <= rd_odd_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_even <= 1'b0;
      hit_odd <= 1'b0;
    end else begin
      hit_even <= rd_en_q && even_vld && (even_entry.tag == even_tag_q);
      hit_odd <= rd_en_q && odd_vld && (odd_entry.tag == odd_tag_q);
    end
    excl_even <= even_entry.excl;
    excl_odd <= odd_entry.excl;
  end

  a_hits_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({hit_even, hit_odd})
  );

endmodule

// ==== src/dc_tag_resolve.sv ====
`timescale 1ns/1ps

module dc_tag_resolve (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rd_en,
  input  logic                          rd_lo_odd,
  input  logic                          rd_split,
  input  logic [dc_tag_pkg::N_WAYS-1:0] hit_even,
  input  logic [dc_tag_pkg::N_WAYS-1:0] hit_odd,
  input  logic [dc_tag_pkg::N_WAYS-1:0] excl_even,
  input  logic [dc_tag_pkg::N_WAYS-1:0] excl_odd,
  output logic                          rsp_valid,
  output logic                          rsp_hit_lo,
  output logic                          rsp_hit_hi,
  output logic [dc_tag_pkg::WAY_W-1:0]  rsp_way_lo,
  output logic [dc_tag_pkg::WAY_W-1:0]  rsp_way_hi,
  output logic                          rsp_excl_lo,
  output logic                          rsp_excl_hi,
  output logic                          rsp_multi_hit
);
  import dc_tag_pkg::*;

  logic en_s1;
  logic en_s2;
  logic lo_odd_s1;
  logic lo_odd_s2;
  logic split_s1;
  logic split_s2;
  logic [N_WAYS-1:0] hit_lo;
  logic [N_WAYS-1:0] hit_hi;
  logic [N_WAYS-1:0] excl_lo;
  logic [N_WAYS-1:0] excl_hi;

  // lowest set bit wins, zero when nothing is set
  function automatic logic [WAY_W-1:0] first_way(input logic [N_WAYS-1:0] v);
    logic [WAY_W-1:0] w;
    w = '0;
    for (int i = N_WAYS - 1; i >= 0; i--) begin
      if (v[i]) begin
        w = WAY_W'(i);
      end
    end
    return w;
  endfunction

  // controls keep pace with the bank read and the hit register in the ways
  always_ff @(posedge clk) begin
    if (rst) begin
      en_s1 <= 1'b0;
      en_s2 <= 1'b0;
    end else begin
      en_s1 <= rd_en;
      en_s2 <= en_s1;
    end
    lo_odd_s1 <= rd_lo_odd;
    lo_odd_s2 <= lo_odd_s1;
    split_s1 <= rd_split;
    split_s2 <= split_s1;
  end

  assign hit_lo = lo_odd_s2 ? hit_odd : hit_even;
  assign hit_hi = split_s2 ? (lo_odd_s2 ? hit_even : hit_odd) : '0;
  assign excl_lo = lo_odd_s2 ? excl_odd : excl_even;
  assign excl_hi = lo_odd_s2 ? excl_even : excl_odd;

  assign rsp_valid = en_s2;
  assign rsp_hit_lo = |hit_lo;
  assign rsp_hit_hi = |hit_hi;
  assign rsp_way_lo = first_way(hit_lo);
  assign rsp_way_hi = first_way(hit_hi);
  assign rsp_excl_lo = rsp_hit_lo ? excl_lo[rsp_way_lo] : 1'b0;
  assign rsp_excl_hi = rsp_hit_hi ? excl_hi[rsp_way_hi] : 1'b0;

  // more than one bit set in either line
  assign rsp_multi_hit = |(hit_lo & (hit_lo - N_WAYS'(1))) ||
                         |(hit_hi & (hit_hi - N_WAYS'(1)));

  a_rsp_hits_known: assert property (
    @(posedge clk) disable iff (rst)
    rsp_valid |-> !$isunknown({hit_even, hit_odd})
  );

endmodule

// ==== src/dc_tag_top.sv ====
`timescale 1ns/1ps

module dc_tag_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req_valid,
  input  logic [dc_tag_pkg::PADDR_W-1:0] req_addr,
  input  logic [dc_tag_pkg::SIZE_W-1:0]  req_size,
  input  logic                           fill_en,
  input  logic [dc_tag_pkg::PADDR_W-1:0] fill_addr,
  input  logic [dc_tag_pkg::WAY_W-1:0]   fill_way,
  input  logic                           fill_excl,
  input  logic                           inv_en,
  input  logic [dc_tag_pkg::PADDR_W-1:0] inv_addr,
  output logic                           init_busy,
  output logic                           rsp_valid,
  output logic                           rsp_hit_lo,
  output logic                           rsp_hit_hi,
  output logic [dc_tag_pkg::WAY_W-1:0]   rsp_way_lo,
  output logic [dc_tag_pkg::WAY_W-1:0]   rsp_way_hi,
  output logic                           rsp_excl_lo,
  output logic                           rsp_excl_hi,
  output logic                           rsp_multi_hit
);
  import dc_tag_pkg::*;

  logic rd_en;
  logic [BANK_IDX_W-1:0] rd_even_idx;
  logic [BANK_IDX_W-1:0] rd_odd_idx;
  logic [TAG_W-1:0] rd_even_tag;
  logic [TAG_W-1:0] rd_odd_tag;
  logic rd_lo_odd;
  logic rd_split;
  logic [N_WAYS-1:0] wr_way_en;
  logic wr_odd;
  logic wr_both;
  logic [BANK_IDX_W-1:0] wr_idx;
  dc_tag_entry_t wr_entry;
  logic wr_valid;
  logic [N_WAYS-1:0] hit_even;
  logic [N_WAYS-1:0] hit_odd;
  logic [N_WAYS-1:0] excl_even;
  logic [N_WAYS-1:0] excl_odd;

  dc_tag_req_stage req_stage_i (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .req_size(req_size),
    .fill_en(fill_en),
    .fill_addr(fill_addr),
    .fill_way(fill_way),
    .fill_excl(fill_excl),
    .inv_en(inv_en),
    .inv_addr(inv_addr),
    .init_busy(init_busy),
    .rd_en(rd_en),
    .rd_even_idx(rd_even_idx),
    .rd_odd_idx(rd_odd_idx),
    .rd_even_tag(rd_even_tag),
    .rd_odd_tag(rd_odd_tag),
    .rd_lo_odd(rd_lo_odd),
    .rd_split(rd_split),
    .wr_way_en(wr_way_en),
    .wr_odd(wr_odd),
    .wr_both(wr_both),
    .wr_idx(wr_idx),
    .wr_entry(wr_entry),
    .wr_valid(wr_valid)
  );

  for (genvar w = 0; w < N_WAYS; w++) begin : g_way
    dc_tag_way way_i (
      .clk(clk),
      .rst(rst),
      .rd_en(rd_en),
      .rd_even_idx(rd_even_idx),
      .rd_odd_idx(rd_odd_idx),
      .rd_even_tag(rd_even_tag),
      .rd_odd_tag(rd_odd_tag),
      .wr_en(wr_way_en[w]),
      .wr_odd(wr_odd),
      .wr_both(wr_both),
      .wr_idx(wr_idx),
      .wr_entry(wr_entry),
      .wr_valid(wr_valid),
      .hit_even(hit_even[w]),
      .hit_odd(hit_odd[w]),
      .excl_even(excl_even[w]),
      .excl_odd(excl_odd[w])
    );
  end

  dc_tag_resolve resolve_i (
    .clk(clk),
    .rst(rst),
    .rd_en(rd_en),
    .rd_lo_odd(rd_lo_odd),
    .rd_split(rd_split),
    .hit_even(hit_even),
    .hit_odd(hit_odd),
    .excl_even(excl_even),
    .excl_odd(excl_odd),
    .rsp_valid(rsp_valid),
    .rsp_hit_lo(rsp_hit_lo),
    .rsp_hit_hi(rsp_hit_hi),
    .rsp_way_lo(rsp_way_lo),
    .rsp_way_hi(rsp_way_hi),
    .rsp_excl_lo(rsp_excl_lo),
    .rsp_excl_hi(rsp_excl_hi),
    .rsp_multi_hit(rsp_multi_hit)
  );

endmodule

// ==== sim/dc_tag_clk_gen.sv ====
`timescale 1ns/1ps

module dc_tag_clk_gen #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release a little after the edge, like the other testbench inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

// ==== sim/dc_tag_tb.sv ====
`timescale 1ns/1ps

module dc_tag_tb;
  import dc_tag_pkg::*;

  localparam string TESTS_FILE = "sim/dc_tag_tests.txt";
  localparam int DRIVE_DELAY = 2;
  localparam int INIT_LIMIT = 70;
  localparam int DRAIN_LIMIT = 10;
  localparam int unsigned SEED = 32'h749fbe4b;

  typedef struct packed {
    logic [7:0]         kind;
    logic [PADDR_W-1:0] addr;
    logic [SIZE_W-1:0]  size;
    logic [WAY_W-1:0]   way;
    logic               excl;
    logic               hit_lo;
    logic               hit_hi;
    logic [WAY_W-1:0]   way_lo;
    logic [WAY_W-1:0]   way_hi;
    logic               excl_lo;
    logic               excl_hi;
    logic               multi_hit;
  } cmd_t;

  logic clk;
  logic rst;
  logic req_valid;
  logic [PADDR_W-1:0] req_addr;
  logic [SIZE_W-1:0] req_size;
  logic fill_en;
  logic [PADDR_W-1:0] fill_addr;
  logic [WAY_W-1:0] fill_way;
  logic fill_excl;
  logic inv_en;
  logic [PADDR_W-1:0] inv_addr;
  logic init_busy;
  logic rsp_valid;
  logic rsp_hit_lo;
  logic rsp_hit_hi;
  logic [WAY_W-1:0] rsp_way_lo;
  logic [WAY_W-1:0] rsp_way_hi;
  logic rsp_excl_lo;
  logic rsp_excl_hi;
  logic rsp_multi_hit;

  cmd_t cmds[$];
  cmd_t exp_q[$];
  int unsigned exp_cyc_q[$];
  int unsigned cycle = 0;
  int unsigned cycle_limit = 0;
  int value_errs = 0;
  int other_errs = 0;
  int timeout_errs = 0;

  dc_tag_clk_gen clk_gen_i (
    .clk(clk),
    .rst(rst)
  );

  dc_tag_top dc_tag_top_i (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .req_size(req_size),
    .fill_en(fill_en),
    .fill_addr(fill_addr),
    .fill_way(fill_way),
    .fill_excl(fill_excl),
    .inv_en(inv_en),
    .inv_addr(inv_addr),
    .init_busy(init_busy),
    .rsp_valid(rsp_valid),
    .rsp_hit_lo(rsp_hit_lo),
    .rsp_hit_hi(rsp_hit_hi),
    .rsp_way_lo(rsp_way_lo),
    .rsp_way_hi(rsp_way_hi),
    .rsp_excl_lo(rsp_excl_lo),
    .rsp_excl_hi(rsp_excl_hi),
    .rsp_multi_hit(rsp_multi_hit)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic load_tests();
    int fd;
    int n;
    int sz, w, e, hl, hh, wl, wh, el, eh, mh;
    string line;
    string rest;
    logic [PADDR_W-1:0] addr;
    cmd_t c;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s", TESTS_FILE);
      other_errs++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 1 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      c = '0;
      c.kind = line.getc(0);
      rest = line.substr(1, line.len() - 1);
      n = 0;
      case (c.kind)
        "F": n = $sscanf(rest, "%h %d %d", addr, w, e) == 3 ? 1 : 0;
        "I": n = $sscanf(rest, "%h", addr) == 1 ? 1 : 0;
        "N": n = 1;
        "L": n = $sscanf(rest, "%h %d %d %d %d %d %d %d %d",
                         addr, sz, hl, hh, wl, wh, el, eh, mh) == 9 ? 1 : 0;
        default: n = 0;
      endcase
      if (n == 0) begin
        $display("unreadable line in tests file: %s", line);
        other_errs++;
        continue;
      end
      c.addr = addr;
      c.size = SIZE_W'(sz);
      c.way = WAY_W'(w);
      c.excl = e[0];
      c.hit_lo = hl[0];
      c.hit_hi = hh[0];
      c.way_lo = WAY_W'(wl);
      c.way_hi = WAY_W'(wh);
      c.excl_lo = el[0];
      c.excl_hi = eh[0];
      c.multi_hit = mh[0];
      cmds.push_back(c);
    end
    $fclose(fd);
  endtask

  // called at posedge + drive delay, returns one cycle later with strobes low
  task automatic issue(input cmd_t c);
    case (c.kind)
      "F": begin
        fill_en = 1'b1;
        fill_addr = c.addr;
        fill_way = c.way;
        fill_excl = c.excl;
      end
      "I": begin
        inv_en = 1'b1;
        inv_addr = c.addr;
      end
      "L": begin
        req_valid = 1'b1;
        req_addr = c.addr;
        req_size = c.size;
        exp_q.push_back(c);
        exp_cyc_q.push_back(cycle + 1);
      end
      default: begin
      end
    endcase
    @(posedge clk);
    #(DRIVE_DELAY);
    req_valid = 1'b0;
    fill_en = 1'b0;
    inv_en = 1'b0;
  endtask

  task automatic report_mismatch(input string name, input logic [PADDR_W-1:0] addr,
                                 input logic [7:0] got, input logic [7:0] exp);
    $display("ERROR %0t: %s got %0h expected %0h (lookup %h)", $time, name, got, exp, addr);
    value_errs++;
  endtask

  task automatic check_response();
    cmd_t e;
    int unsigned sampled;
    if (exp_q.size() == 0) begin
      $display("response at %0t with no lookup outstanding", $time);
      other_errs++;
      return;
    end
    e = exp_q.pop_front();
    sampled = exp_cyc_q.pop_front();
    if (cycle - sampled != 2) begin
      $display("lookup %h answered %0d cycles after it was sampled instead of 2",
               e.addr, cycle - sampled);
      other_errs++;
    end
    if (rsp_hit_lo !== e.hit_lo) begin
      report_mismatch("rsp_hit_lo", e.addr, 8'(rsp_hit_lo), 8'(e.hit_lo));
    end
    if (rsp_hit_hi !== e.hit_hi) begin
      report_mismatch("rsp_hit_hi", e.addr, 8'(rsp_hit_hi), 8'(e.hit_hi));
    end
    if (rsp_way_lo !== e.way_lo) begin
      report_mismatch("rsp_way_lo", e.addr, 8'(rsp_way_lo), 8'(e.way_lo));
    end
    if (rsp_way_hi !== e.way_hi) begin
      report_mismatch("rsp_way_hi", e.addr, 8'(rsp_way_hi), 8'(e.way_hi));
    end
    if (rsp_excl_lo !== e.excl_lo) begin
      report_mismatch("rsp_excl_lo", e.addr, 8'(rsp_excl_lo), 8'(e.excl_lo));
    end
    if (rsp_excl_hi !== e.excl_hi) begin
      report_mismatch("rsp_excl_hi", e.addr, 8'(rsp_excl_hi), 8'(e.excl_hi));
    end
    if (rsp_multi_hit !== e.multi_hit) begin
      report_mismatch("rsp_multi_hit", e.addr, 8'(rsp_multi_hit), 8'(e.multi_hit));
    end
  endtask

  task automatic close_run();
    $display("errors: %0d value, %0d other, %0d timeout", value_errs, other_errs, timeout_errs);
    if (value_errs + other_errs + timeout_errs != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst && rsp_valid === 1'b1) begin
      check_response();
    end
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycle < cycle_limit) begin
      @(posedge clk);
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    timeout_errs++;
    close_run();
  end

  initial begin
    int unsigned gap;
    int unsigned waited;
    bit prev_lookup;
    req_valid = 1'b0;
    req_addr = '0;
    req_size = '0;
    fill_en = 1'b0;
    fill_addr = '0;
    fill_way = '0;
    fill_excl = 1'b0;
    inv_en = 1'b0;
    inv_addr = '0;
    void'($urandom(SEED));
    load_tests();
    cycle_limit = 64 + 5 * cmds.size() + 50;

    do begin
      @(posedge clk);
    end while (rst);
    #(DRIVE_DELAY);
    if (init_busy !== 1'b1) begin
      $display("init_busy is not high after reset release");
      other_errs++;
    end
    waited = 1;
    while (init_busy === 1'b1 && waited < INIT_LIMIT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      waited++;
    end
    if (init_busy !== 1'b0) begin
      $display("init_busy still high %0d cycles after reset release", INIT_LIMIT);
      other_errs++;
      close_run();
    end else begin
      // lookup runs stay back to back, other commands get a random gap
      prev_lookup = 1'b0;
      foreach (cmds[i]) begin
        if (!(prev_lookup && cmds[i].kind == "L")) begin
          gap = $urandom % 3;
          repeat (gap) begin
            @(posedge clk);
            #(DRIVE_DELAY);
          end
        end
        issue(cmds[i]);
        prev_lookup = (cmds[i].kind == "L");
      end

      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      // a few more cycles to catch stray responses
      repeat (4) @(posedge clk);
      if (exp_q.size() != 0) begin
        $display("%0d lookups never got a response", exp_q.size());
        other_errs++;
      end
      close_run();
    end
  end

endmodule

// ==== sources.f ====
src/dc_tag_pkg.sv
src/dc_tag_ram.sv
src/dc_tag_req_stage.sv
src/dc_tag_way.sv
src/dc_tag_resolve.sv
src/dc_tag_top.sv
sim/dc_tag_clk_gen.sv
sim/dc_tag_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= dc_tag_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= sim passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the tests file path inside the testbench is relative to this directory
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/dc_tag_tests.txt ====
# F addr way excl | I addr | N (idle) | L addr size, then expected
# hit_lo hit_hi way_lo way_hi excl_lo excl_hi multi_hit; addr in hex, the rest decimal
L 00000000000 8 0 0 0 0 0 0 0
L 123456789ab 8 0 0 0 0 0 0 0
L 000000021bc 8 0 0 0 0 0 0 0
F 00000002180 0 1
F 000000021c0 1 0
F 00000004200 2 1
F 00000006240 3 0
N
L 00000002180 4 1 0 0 0 1 0 0
L 000000021d0 8 1 0 1 0 0 0 0
L 00000004208 8 1 0 2 0 1 0 0
L 00000006278 8 1 0 3 0 0 0 0
L 0000000a180 1 0 0 0 0 0 0 0
L 000000021bc 8 1 1 0 1 1 0 0
L 000000021ff 2 1 0 1 0 0 0 0
F 00000002200 3 1
L 000000021fc 8 1 1 1 3 0 1 0
L 00000002180 8 1 0 0 0 1 0 0
I 00000002180
L 00000002180 1 0 0 0 0 0 0 0
L 000000021c0 8 1 0 1 0 0 0 0
L 00000004200 8 1 0 2 0 1 0 0
I 0000000e240
N
L 00000006240 8 0 0 0 0 0 0 0
F 00000008300 1 1
F 00000008300 2 0
L 00000008300 4 1 0 1 0 1 0 1
L 00000008304 8 1 0 1 0 1 0 1
L 000000082fc 8 0 1 0 1 0 1 1
L 000000021c0 8 1 0 1 0 0 0 0
L 00000002180 8 0 0 0 0 0 0 0
L 000000021fc 8 1 1 1 3 0 1 0
